//--- Bender.yml
package:
  name: ddr_sched

sources:
  - rtl/ddr_pkg.sv
  - rtl/rr_arbiter.sv
  - rtl/timing_controller.sv
  - rtl/burst_slots.sv
  - rtl/ddr_sched_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/ddr_sched_tb.sv

//--- rtl/burst_slots.sv
`timescale 1ns/1ps

module burst_slots import ddr_pkg::*; (
	input  logic                       clk,
	input  logic                       rst_n,
	input  host_req_t                  req,
	output logic                       credit,     // one pulse per freed slot
	output slot_view_t [num_slots-1:0] slots,
	input  cmd_e       [num_slots-1:0] slot_cmd,
	output dram_cmd_t                  dram_cmd_o
);

	slot_state_e [num_slots-1:0] state;
	req_kind_e   [num_slots-1:0] kind;
	address_t    [num_slots-1:0] addr;
	logic [num_slots-1:0][hold_len-1:0] hold; // data time left

	logic                    free_found;
	logic [slot_idx_len-1:0] free_idx;  // lowest empty slot
	logic [num_slots-1:0]    accept;
	logic [num_slots-1:0]    col_issue; // column command seen this cycle
	logic [num_slots-1:0]    expire;    // last cycle of hold

	always_comb begin
		free_found = 1'b0;
		free_idx   = '0;
		for (int i = num_slots - 1; i >= 0; i--) begin // downward so lowest wins
			if (state[i] == empty) begin
				free_found = 1'b1;
				free_idx   = slot_idx_len'(i);
			end
		end
	end

	always_comb begin
		for (int i = 0; i < num_slots; i++) begin
			accept[i]    = req.valid && free_found && (free_idx == slot_idx_len'(i));
			col_issue[i] = (state[i] == full) &&
			               (slot_cmd[i] == read_cmd || slot_cmd[i] == write_cmd);
			expire[i]    = (state[i] == returning_data) && (hold[i] == hold_len'(1));
		end
	end

	// slot state machine
	always_ff @(posedge clk) begin
		if (rst_n) begin
			for (int i = 0; i < num_slots; i++) begin
				state[i] <= empty;
			end
			credit <= 1'b0;
		end else begin
			credit <= |expire; // registered, lands with the slot going empty
			for (int i = 0; i < num_slots; i++) begin
				case (state[i])
					empty: begin
						if (accept[i]) state[i] <= full; // visible next cycle
					end
					full: begin
						if (col_issue[i]) state[i] <= returning_data;
					end
					returning_data: begin
						if (expire[i]) state[i] <= empty;
					end
					default: state[i] <= empty;
				endcase
			end
		end
	end

	// payload and hold count
	always_ff @(posedge clk) begin
		for (int i = 0; i < num_slots; i++) begin
			if (accept[i]) begin
				kind[i] <= req.kind;
				addr[i] <= req.addr;
			end
			if (col_issue[i]) begin
				hold[i] <= (slot_cmd[i] == read_cmd) ? hold_len'(rd_hold) : hold_len'(wr_hold);
			end else if (state[i] == returning_data) begin
				hold[i] <= hold[i] - 1'b1;
			end
		end
	end

	always_comb begin
		for (int i = 0; i < num_slots; i++) begin
			slots[i].state = state[i];
			slots[i].kind  = kind[i];
			slots[i].addr  = addr[i];
		end
	end

	// dram bus word, straight from registered slot_cmd and slot address
	always_comb begin
		dram_cmd_o.cmd  = none;
		dram_cmd_o.addr = '0;
		dram_cmd_o.slot = '0;
		for (int i = 0; i < num_slots; i++) begin
			if (slot_cmd[i] != none) begin
				dram_cmd_o.cmd  = slot_cmd[i];
				dram_cmd_o.addr = addr[i];
				dram_cmd_o.slot = slot_idx_len'(i);
			end
		end
	end

	no_free_slot: assert property (@(posedge clk) disable iff (rst_n)
		req.valid |-> free_found)
		else $error("host request with no empty slot, credit overrun");

	// column spacing keeps the data windows apart, one credit per cycle is enough
	single_expire: assert property (@(posedge clk) disable iff (rst_n)
		$onehot0(expire))
		else $error("two slots freed together, a credit would be lost");

	for (genvar s = 0; s < num_slots; s++) begin : g_cmd_chk
		cmd_to_full_slot: assert property (@(posedge clk) disable iff (rst_n)
			(slot_cmd[s] != none) |-> (state[s] == full))
			else $error("command for slot %0d which holds no request", s);
	end

endmodule

//--- rtl/ddr_pkg.sv
package ddr_pkg;

	// geometry
	localparam int num_slots       = 4;
	localparam int slot_idx_len    = $clog2(num_slots);
	localparam int bank_groups     = 4;
	localparam int banks_per_group = 4;
	localparam int banks_no        = bank_groups * banks_per_group; // 16 banks
	localparam int bg_len          = $clog2(bank_groups);
	localparam int bank_len        = $clog2(banks_per_group);
	localparam int bank_idx_len    = bg_len + bank_len; // flat bank index {bg, bank}
	localparam int row_len         = 15;
	localparam int col_len         = 10;

	// same bank timing, in clocks
	localparam int act_to_rd            = 6;  // also act to write
	localparam int pre_to_act           = 6;
	localparam int act_to_act_same_bank = 20;
	localparam int act_to_pre           = 14;
	localparam int rd_to_pre            = 3;
	localparam int wr_to_pre            = 6;

	// cross bank and bus timing
	localparam int act_to_act_diff_bank = 3;
	localparam int rd_to_wr             = 5;
	localparam int wr_to_rd             = 9;
	localparam int rd_to_rd             = 2;  // column to column
	localparam int rd_to_data           = 6;
	localparam int wr_to_data           = 4;
	localparam int burst_time           = 8;

	// slot hold after a column command
	localparam int rd_hold  = burst_time + rd_to_data;
	localparam int wr_hold  = burst_time + wr_to_data;
	localparam int hold_len = $clog2(rd_hold + 1); // rd_hold is the longer one

	// elapsed-time counters saturate at all ones
	localparam int cnt_len = 5; // holds act_to_act_same_bank - 1
	localparam logic [cnt_len-1:0] cnt_sat = '1;

	typedef struct packed {
		logic [bg_len-1:0]   bank_group;
		logic [bank_len-1:0] bank;
		logic [row_len-1:0]  row;
		logic [col_len-1:0]  col;
	} address_t;

	typedef enum logic {
		read,
		write
	} req_kind_e;

	typedef enum logic [2:0] {
		none,
		activate,
		read_cmd,
		write_cmd,
		precharge
	} cmd_e;

	typedef struct packed {
		logic      valid;
		req_kind_e kind;
		address_t  addr;
	} host_req_t;

	typedef enum logic [1:0] {
		empty,
		full,
		returning_data
	} slot_state_e;

	typedef struct packed {
		slot_state_e state;
		req_kind_e   kind;
		address_t    addr;
	} slot_view_t;

	typedef struct packed {
		cmd_e                    cmd;
		address_t                addr;
		logic [slot_idx_len-1:0] slot; // slot that owns the command
	} dram_cmd_t;

endpackage

//--- rtl/ddr_sched_top.sv
`timescale 1ns/1ps

module ddr_sched_top import ddr_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  host_req_t req,        // host posts only while holding credit
	output logic      credit,
	output dram_cmd_t dram_cmd_o  // registered command bus
);

	slot_view_t [num_slots-1:0] slots;    // slot contents seen by the scheduler
	cmd_e       [num_slots-1:0] slot_cmd; // granted command, one slot at most

	// request storage, slot FSMs, credits and bus word
	burst_slots u_slots (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.credit    (credit),
		.slots     (slots),
		.slot_cmd  (slot_cmd),
		.dram_cmd_o(dram_cmd_o)
	);

	// timing rules and round-robin pick
	timing_controller u_tc (
		.clk     (clk),
		.rst_n   (rst_n),
		.slots   (slots),
		.slot_cmd(slot_cmd)
	);

endmodule

//--- rtl/rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter #(
	parameter int n = 4
) (
	input  logic [n-1:0]         req,
	input  logic [$clog2(n)-1:0] start, // position with top priority
	output logic [n-1:0]         grant
);

	logic [2*n-1:0] req_dbl;  // doubled for rotate right
	logic [n-1:0]   req_rot;  // start moved to bit 0
	logic [n-1:0]   pick_rot; // lowest set bit of rotated vector
	logic [2*n-1:0] pick_dbl; // doubled for rotate back

	always_comb begin
		req_dbl  = {req, req} >> start;
		req_rot  = req_dbl[n-1:0];
		pick_rot = req_rot & (~req_rot + 1'b1); // two's complement isolates first one
		pick_dbl = {pick_rot, pick_rot} << start;
		grant    = pick_dbl[2*n-1:n]; // upper half is the left rotation

		// no clock here, so the check settles at the end of the time step
		grant_onehot_subset: assert final ($onehot0(grant) && ((grant & ~req) == '0))
			else $error("rr_arbiter grant %b not one-hot within req %b", grant, req);
	end

endmodule

//--- rtl/timing_controller.sv
`timescale 1ns/1ps

module timing_controller import ddr_pkg::*; (
	input  logic                       clk,
	input  logic                       rst_n,
	input  slot_view_t [num_slots-1:0] slots,
	output cmd_e       [num_slots-1:0] slot_cmd // registered, at most one active
);

	// elapsed clocks since the last command of each kind, saturating
	logic [banks_no-1:0][cnt_len-1:0]    bank_act_cnt;
	logic [banks_no-1:0][cnt_len-1:0]    bank_rd_cnt;
	logic [banks_no-1:0][cnt_len-1:0]    bank_wr_cnt;
	logic [banks_no-1:0][cnt_len-1:0]    bank_pre_cnt;
	logic [bank_groups-1:0][cnt_len-1:0] bg_act_cnt;
	logic [cnt_len-1:0] bus_rd_cnt; // since any read
	logic [cnt_len-1:0] bus_wr_cnt; // since any write
	req_kind_e last_col;            // kind of the last column command

	logic [banks_no-1:0][row_len-1:0] open_row;
	logic [banks_no-1:0]              open_valid;
	logic [slot_idx_len-1:0]          rr_start;

	logic [num_slots-1:0][bank_idx_len-1:0] slot_bank;
	cmd_e [num_slots-1:0] cand;       // candidate per slot
	logic [num_slots-1:0] elig;
	logic [num_slots-1:0] grant;
	logic [num_slots-1:0] cmd_active; // for the one-hot check
	logic act_spacing_ok;
	logic bus_free;
	logic col_gap_ok;

	logic                    gnt_any;
	logic [slot_idx_len-1:0] gnt_idx;
	cmd_e                    gnt_cmd;
	logic [bank_idx_len-1:0] gnt_bank;
	logic [bg_len-1:0]       gnt_bg;
	logic [row_len-1:0]      gnt_row;

	function automatic logic [cnt_len-1:0] sat_inc(input logic [cnt_len-1:0] c);
		return (c == cnt_sat) ? c : c + 1'b1;
	endfunction

	// a count of t-1 at eligibility gives a gap of t on the bus
	always_comb begin
		act_spacing_ok = 1'b1;
		for (int g = 0; g < bank_groups; g++) begin
			if (bg_act_cnt[g] < act_to_act_diff_bank - 1) act_spacing_ok = 1'b0; // any group
		end
		bus_free   = (bus_rd_cnt >= burst_time - 1) && (bus_wr_cnt >= burst_time - 1);
		col_gap_ok = (bus_rd_cnt >= rd_to_rd - 1) && (bus_wr_cnt >= rd_to_rd - 1);
	end

	always_comb begin
		for (int i = 0; i < num_slots; i++) begin
			slot_bank[i] = {slots[i].addr.bank_group, slots[i].addr.bank};
		end
	end

	always_comb begin
		for (int i = 0; i < num_slots; i++) begin
			cand[i] = none;
			if (slots[i].state == full && slot_cmd[i] == none) begin // skip slot just served
				if (open_valid[slot_bank[i]] && open_row[slot_bank[i]] == slots[i].addr.row) begin
					// row hit, column command
					if (bus_free && col_gap_ok &&
					    bank_act_cnt[slot_bank[i]] >= act_to_rd - 1 &&
					    (slots[i].kind == last_col ||
					     (slots[i].kind == write && bus_rd_cnt >= rd_to_wr - 1) ||
					     (slots[i].kind == read && bus_wr_cnt >= wr_to_rd - 1))) begin
						cand[i] = (slots[i].kind == read) ? read_cmd : write_cmd;
					end
				end else if (open_valid[slot_bank[i]]) begin // row conflict
					if (bank_act_cnt[slot_bank[i]] >= act_to_pre - 1 &&
					    bank_rd_cnt[slot_bank[i]] >= rd_to_pre - 1 &&
					    bank_wr_cnt[slot_bank[i]] >= wr_to_pre - 1) begin
						cand[i] = precharge;
					end
				end else if (bank_pre_cnt[slot_bank[i]] >= pre_to_act - 1 &&
				             bank_act_cnt[slot_bank[i]] >= act_to_act_same_bank - 1 &&
				             act_spacing_ok) begin // bank closed
					cand[i] = activate;
				end
			end
			elig[i] = (cand[i] != none);
		end
	end

	rr_arbiter #(
		.n(num_slots)
	) u_arb (
		.req  (elig),
		.start(rr_start),
		.grant(grant)
	);

	always_comb begin
		gnt_any = |grant;
		gnt_idx = '0;
		for (int i = 0; i < num_slots; i++) begin
			if (grant[i]) gnt_idx = slot_idx_len'(i);
		end
		gnt_cmd  = cand[gnt_idx]; // none when nothing eligible
		gnt_bank = slot_bank[gnt_idx];
		gnt_bg   = slots[gnt_idx].addr.bank_group;
		gnt_row  = slots[gnt_idx].addr.row;
	end

	always_ff @(posedge clk) begin
		if (rst_n) begin
			for (int b = 0; b < banks_no; b++) begin
				bank_act_cnt[b] <= cnt_sat; // nothing pending
				bank_rd_cnt[b]  <= cnt_sat;
				bank_wr_cnt[b]  <= cnt_sat;
				bank_pre_cnt[b] <= cnt_sat;
			end
			for (int g = 0; g < bank_groups; g++) begin
				bg_act_cnt[g] <= cnt_sat;
			end
			bus_rd_cnt <= cnt_sat;
			bus_wr_cnt <= cnt_sat;
			last_col   <= read;
			open_valid <= '0; // all banks closed
			rr_start   <= '0;
			for (int i = 0; i < num_slots; i++) begin
				slot_cmd[i] <= none;
			end
		end else begin
			for (int b = 0; b < banks_no; b++) begin
				bank_act_cnt[b] <= sat_inc(bank_act_cnt[b]);
				bank_rd_cnt[b]  <= sat_inc(bank_rd_cnt[b]);
				bank_wr_cnt[b]  <= sat_inc(bank_wr_cnt[b]);
				bank_pre_cnt[b] <= sat_inc(bank_pre_cnt[b]);
			end
			for (int g = 0; g < bank_groups; g++) begin
				bg_act_cnt[g] <= sat_inc(bg_act_cnt[g]);
			end
			bus_rd_cnt <= sat_inc(bus_rd_cnt);
			bus_wr_cnt <= sat_inc(bus_wr_cnt);
			for (int i = 0; i < num_slots; i++) begin
				slot_cmd[i] <= grant[i] ? cand[i] : none;
			end
			if (gnt_any) begin
				rr_start <= (gnt_idx == slot_idx_len'(num_slots - 1)) ? '0 : gnt_idx + 1'b1;
			end
			case (gnt_cmd) // later assignments override the increments
				activate: begin
					bank_act_cnt[gnt_bank] <= '0;
					bg_act_cnt[gnt_bg]     <= '0;
					open_valid[gnt_bank]   <= 1'b1;
				end
				read_cmd: begin
					bank_rd_cnt[gnt_bank] <= '0;
					bus_rd_cnt            <= '0;
					last_col              <= read;
				end
				write_cmd: begin
					bank_wr_cnt[gnt_bank] <= '0;
					bus_wr_cnt            <= '0;
					last_col              <= write;
				end
				precharge: begin
					bank_pre_cnt[gnt_bank] <= '0;
					open_valid[gnt_bank]   <= 1'b0;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (gnt_cmd == activate) open_row[gnt_bank] <= gnt_row; // row table
	end

	always_comb begin
		for (int i = 0; i < num_slots; i++) begin
			cmd_active[i] = (slot_cmd[i] != none);
		end
	end

	one_cmd_per_cycle: assert property (@(posedge clk) disable iff (rst_n)
		$onehot0(cmd_active))
		else $error("more than one slot commanded in one cycle");

	for (genvar s = 0; s < num_slots; s++) begin : g_col_chk
		// slot address comes from burst_slots, row table from here
		col_hits_open_row: assert property (@(posedge clk) disable iff (rst_n)
			(slot_cmd[s] inside {read_cmd, write_cmd}) |->
				(open_valid[slot_bank[s]] && open_row[slot_bank[s]] == slots[s].addr.row))
			else $error("column command from slot %0d to a closed or other row", s);
	end

endmodule

//--- sources.f
+incdir+tb
rtl/ddr_pkg.sv
rtl/rr_arbiter.sv
rtl/timing_controller.sv
rtl/burst_slots.sv
rtl/ddr_sched_top.sv
tb/ddr_sched_tb.sv

//--- tb/ddr_sched_checks.svh
`ifndef DDR_SCHED_CHECKS_SVH
`define DDR_SCHED_CHECKS_SVH

int last_cyc [banks_no][5] = '{default: '{default: -100}}; // per bank, one per cmd_e code
int any_cyc [5] = '{default: -100};                         // any bank
int open_row_ref [banks_no] = '{default: -1};               // -1 when bank closed

task automatic compare_cmd(string name, cmd_e got, cmd_e exp);
	if (got != exp) begin
		errors++;
		$display("FAILED at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
	end
endtask

task automatic compare_addr(string name, address_t got, address_t exp);
	if (got != exp) begin
		errors++;
		$display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
	end
endtask

task automatic compare_count(string name, int got, int exp);
	if (got != exp) begin
		errors++;
		$display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
	end
endtask

task automatic check_gap(string rule, cmd_e first, int t0, cmd_e second, int t1, int need);
	if (t1 - t0 < need) begin
		rule_errors++;
		$display("ERROR at %0t: timing rule %s broken, %s at cycle %0d then %s at cycle %0d",
			$time, rule, first.name(), t0, second.name(), t1);
	end
endtask

// reference model, fed by the bus monitor
task automatic model_cmd(cmd_e c, address_t a, int cyc);
	int b;
	b = {a.bank_group, a.bank}; // flat bank index
	case (c)
		activate: begin
			if (open_row_ref[b] >= 0) begin
				rule_errors++;
				$display("ERROR at %0t: activate to bank %0d which is still open", $time, b);
			end
			check_gap("pre_to_act", precharge, last_cyc[b][precharge], c, cyc, pre_to_act);
			check_gap("act_to_act_same_bank", activate, last_cyc[b][activate], c, cyc,
				act_to_act_same_bank);
			check_gap("act_to_act_diff_bank", activate, any_cyc[activate], c, cyc,
				act_to_act_diff_bank);
			open_row_ref[b] = a.row;
		end
		read_cmd, write_cmd: begin
			if (open_row_ref[b] != a.row) begin
				rule_errors++;
				$display("ERROR at %0t: %s to bank %0d row %h which is not open",
					$time, c.name(), b, a.row);
			end
			check_gap("act_to_rd", activate, last_cyc[b][activate], c, cyc, act_to_rd);
			check_gap("burst_time", read_cmd, any_cyc[read_cmd], c, cyc, burst_time);
			check_gap("burst_time", write_cmd, any_cyc[write_cmd], c, cyc, burst_time);
			if (c == read_cmd) begin
				check_gap("wr_to_rd", write_cmd, any_cyc[write_cmd], c, cyc, wr_to_rd);
			end else begin
				check_gap("rd_to_wr", read_cmd, any_cyc[read_cmd], c, cyc, rd_to_wr);
			end
		end
		precharge: begin
			check_gap("act_to_pre", activate, last_cyc[b][activate], c, cyc, act_to_pre);
			check_gap("rd_to_pre", read_cmd, last_cyc[b][read_cmd], c, cyc, rd_to_pre);
			check_gap("wr_to_pre", write_cmd, last_cyc[b][write_cmd], c, cyc, wr_to_pre);
			open_row_ref[b] = -1;
		end
		default: ;
	endcase
	last_cyc[b][c] = cyc;
	any_cyc[c]     = cyc;
endtask

`endif

//--- tb/ddr_sched_tb.sv
`timescale 1ns/1ps

module ddr_sched_tb import ddr_pkg::*; ();

	localparam int clk_period   = 40;
	localparam int rand_reqs    = 12;
	localparam int total_reqs   = 1 + 2 + bank_groups + rand_reqs;
	localparam int req_tests    = 4;           // tests that post requests
	localparam int quiet_cycles = rd_hold + 1; // longest column to credit distance
	localparam int path_cycles  = act_to_pre + act_to_act_same_bank + act_to_rd + wr_to_rd +
		burst_time + rd_to_data + 1; // close, open, column, hold

	logic      clk;
	logic      rst_n;
	host_req_t req;
	logic      credit;
	dram_cmd_t dram_cmd_o;

	int     errors      = 0; // value mismatches
	int     rule_errors = 0; // timing model violations
	int     cycle       = 0;
	int     credits;         // host side credits
	integer seed        = 32'h69440025;

	req_kind_e req_kind_q[$]; // requests of current test
	address_t  req_addr_q[$];
	cmd_e      log_cmd[$];    // bus log of current test
	address_t  log_addr[$];
	int        log_slot[$];   // owning slot of each bus command
	int        log_cyc[$];
	int        credit_cyc[$];

	`include "ddr_sched_checks.svh"

	ddr_sched_top DUT (.*);

	initial clk = 1'b0;
	always #(clk_period / 2) clk = ~clk;
	always @(posedge clk) cycle <= cycle + 1;

	// bus monitor samples settled outputs mid cycle
	always @(negedge clk) begin
		if (!rst_n) begin
			if (dram_cmd_o.cmd != none) begin
				log_cmd.push_back(dram_cmd_o.cmd);
				log_addr.push_back(dram_cmd_o.addr);
				log_slot.push_back(dram_cmd_o.slot);
				log_cyc.push_back(cycle);
				model_cmd(dram_cmd_o.cmd, dram_cmd_o.addr, cycle);
			end
			if (credit) credit_cyc.push_back(cycle);
		end
	end

	task automatic clear_log();
		req_kind_q.delete();
		req_addr_q.delete();
		log_cmd.delete();
		log_addr.delete();
		log_slot.delete();
		log_cyc.delete();
		credit_cyc.delete();
	endtask

	task automatic add_req(req_kind_e k, int bg, int bank, int row, int col);
		req_kind_q.push_back(k);
		req_addr_q.push_back('{bank_group: bg_len'(bg), bank: bank_len'(bank),
			row: row_len'(row), col: col_len'(col)});
	endtask

	// posts queued requests while credits last and waits until all credits are back
	task automatic issue_requests();
		int idx;
		int returned;
		idx      = 0;
		returned = 0;
		while (returned < req_addr_q.size()) begin
			if (credit) begin
				credits++;
				returned++;
			end
			req = '0;
			if (idx < req_addr_q.size() && credits > 0) begin
				req.valid = 1'b1;
				req.kind  = req_kind_q[idx];
				req.addr  = req_addr_q[idx];
				credits--;
				idx++;
			end
			@(negedge clk); // next drive point
		end
		repeat (quiet_cycles) @(negedge clk); // stray commands or credits land in the log
	endtask

	function automatic int col_hits(req_kind_e k, address_t a);
		int n;
		n = 0;
		foreach (log_cmd[i]) begin
			if (log_cmd[i] == ((k == read) ? read_cmd : write_cmd) && log_addr[i] == a) n++;
		end
		return n;
	endfunction

	function automatic int col_slot(req_kind_e k, address_t a);
		int s;
		s = -1;
		foreach (log_cmd[i]) begin
			if (log_cmd[i] == ((k == read) ? read_cmd : write_cmd) && log_addr[i] == a)
				s = log_slot[i];
		end
		return s;
	endfunction

	task automatic check_served();
		foreach (req_addr_q[i]) begin
			compare_count($sformatf("column commands for request %0d", i),
				col_hits(req_kind_q[i], req_addr_q[i]), 1);
		end
		compare_count("credit pulses", credit_cyc.size(), req_addr_q.size());
		compare_count("host credits", credits, num_slots);
	endtask

	task automatic test_reset();
		repeat (6) begin
			compare_cmd("dram_cmd_o.cmd", dram_cmd_o.cmd, none);
			compare_count("credit", credit, 0);
			@(negedge clk);
		end
	endtask

	task automatic test_closed_read();
		clear_log();
		add_req(read, 1, 2, 'h1234, 'h10);
		issue_requests();
		compare_count("bus commands", log_cmd.size(), 2);
		if (log_cmd.size() == 2 && credit_cyc.size() == 1) begin
			compare_cmd("first command", log_cmd[0], activate);
			compare_cmd("second command", log_cmd[1], read_cmd);
			compare_addr("activate address", log_addr[0], req_addr_q[0]);
			compare_addr("read address", log_addr[1], req_addr_q[0]);
			compare_count("activate slot", log_slot[0], 0); // all slots empty, lowest taken
			compare_count("read slot", log_slot[1], 0);
			compare_count("read to credit cycles", credit_cyc[0] - log_cyc[1],
				burst_time + rd_to_data + 1);
		end
		check_served();
	endtask

	task automatic test_row_conflict();
		cmd_e exp_seq [5] = '{activate, write_cmd, precharge, activate, read_cmd};
		int   exp_slot [5] = '{0, 0, 1, 1, 1}; // second request waits in slot 1
		clear_log();
		add_req(write, 2, 1, 'h0100, 'h20); // same bank with two rows
		add_req(read, 2, 1, 'h0200, 'h21);
		issue_requests();
		compare_count("bus commands", log_cmd.size(), 5);
		foreach (exp_seq[i]) begin
			if (i < log_cmd.size()) begin
				compare_cmd($sformatf("command %0d", i), log_cmd[i], exp_seq[i]);
				compare_count($sformatf("slot of command %0d", i), log_slot[i], exp_slot[i]);
			end
		end
		check_served();
	endtask

	task automatic test_bank_groups();
		clear_log();
		for (int g = 0; g < bank_groups; g++) begin
			add_req(read, g, 3, 'h0300 + g, 'h30 + g);
		end
		issue_requests();
		for (int g = 0; g < bank_groups; g++) begin // posted back to back into slots 0 to 3
			compare_count($sformatf("slot of request %0d", g), col_slot(read, req_addr_q[g]), g);
		end
		check_served(); // activate spacing checked by model
	endtask

	task automatic test_mixed();
		int        b;
		req_kind_e k;
		clear_log();
		for (int i = 0; i < rand_reqs; i++) begin
			b = $random(seed) & 'h7;                   // eight banks with one row each
			k = req_kind_e'($random(seed) & 1);
			add_req(k, b & 3, b >> 2, 'h4000 + b, 'h40 + i); // column keeps addresses unique
		end
		issue_requests();
		check_served();
	endtask

	initial begin
		rst_n   = 1'b1; // reset asserted
		req     = '0;
		credits = num_slots;
		repeat (10) @(negedge clk);
		rst_n = 1'b0;
		@(negedge clk);
		test_reset();
		test_closed_read();
		test_row_conflict();
		test_bank_groups();
		test_mixed();
		$display("%0d value errors, %0d timing rule errors", errors, rule_errors);
		if (errors == 0 && rule_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// watchdog allows every request the slowest path one after another
	initial begin
		#((total_reqs * path_cycles + req_tests * quiet_cycles + 100) * clk_period);
		$display("timeout at cycle %0d, the DUT stopped returning credits", cycle);
		$display("Some tests failed");
		$finish;
	end

endmodule
